// File: include/stressDefines.svh
// Stress block register map shared by RTL and testbench.
`ifndef STRESS_DEFINES_SVH
`define STRESS_DEFINES_SVH

`define STRESS_ADDR_ID         4'd0
`define STRESS_ADDR_CONTROL    4'd1  // Bit 0 go, bit 31 done.
`define STRESS_ADDR_PARAM      4'd2
`define STRESS_ADDR_CHUNK      4'd3
`define STRESS_ADDR_TESTCHUNKS 4'd4
`define STRESS_ADDR_SAMPLES    4'd5
`define STRESS_ADDR_RESULT0    4'd6  // One word per lane from here up.

`define STRESS_CONTROL_RW_MASK 32'h0000_0001

`endif

// File: logic/stressPkg.sv
// Stress package with sizes, register typedefs, ID word and the mixing stage function.
package stressPkg;

  localparam int LaneCount    = 2;
  localparam int DataWidth    = 32;
  localparam int PipeStages   = 4;
  localparam int PrescaleBits = 6;   // 64 cycles per chunk.
  localparam int RunDelay     = 2;
  localparam int CsrAddrWidth = 4;

  localparam int RotateBits   = 5;

  typedef logic [DataWidth-1:0]    laneData_t;
  typedef logic [CsrAddrWidth-1:0] csrAddr_t;
  typedef logic [31:0]             csrData_t;
  typedef logic [31:0]             chunk_t;

  localparam csrData_t StressId = {16'h57e5, 8'h00, 8'(LaneCount)};

  // One key per mixing stage.
  localparam laneData_t StageKeys [PipeStages] = '{
    32'h9e37_79b9,
    32'h7f4a_7c15,
    32'hbb67_ae85,
    32'h3c6e_f372
  };

  // Rotate left then add the stage key, wrapping at the word size.
  function automatic laneData_t mixStage(laneData_t value, laneData_t key);
    laneData_t rotated;
    rotated = {value[DataWidth-RotateBits-1:0], value[DataWidth-1:DataWidth-RotateBits]};
    return rotated + key;
  endfunction

endpackage

// File: logic/csrBlock.sv
// CSR register file holding run control and returning status, parameters and lane results.
`timescale 1ns/1ns
`include "stressDefines.svh"

module csrBlock (
  input  logic                 clock,
  input  logic                 resetSync,
  input  logic                 csrWrite,
  input  logic                 csrRead,
  input  stressPkg::csrAddr_t  csrAddress,
  input  stressPkg::csrData_t  csrWriteData,
  input  logic                 done,
  input  stressPkg::chunk_t    chunk,
  input  stressPkg::csrData_t  sampleCount,
  input  stressPkg::laneData_t laneSum [stressPkg::LaneCount],
  output stressPkg::csrData_t  csrReadData,
  output logic                 csrReadValid,
  output logic                 go,
  output stressPkg::chunk_t    testChunks
);

  stressPkg::csrData_t readWord;
  stressPkg::csrData_t controlWord;
  stressPkg::csrData_t paramWord;

  assign controlWord = {done, 30'd0, go};
  assign paramWord   = {16'(stressPkg::DataWidth), 16'(stressPkg::PipeStages)};

  // RW fields. RO bits are never stored.
  always_ff @(posedge clock) begin
    if (resetSync) begin
      go         <= 1'b0;
      testChunks <= '0;
    end else if (csrWrite) begin
      if (csrAddress == `STRESS_ADDR_CONTROL) begin
        go <= |(csrWriteData & `STRESS_CONTROL_RW_MASK);
      end
      if (csrAddress == `STRESS_ADDR_TESTCHUNKS) begin
        testChunks <= csrWriteData;
      end
    end
  end

  // Read mux. Unmapped addresses return zero.
  always_comb begin
    readWord = '0;
    case (csrAddress)
      `STRESS_ADDR_ID:         readWord = stressPkg::StressId;
      `STRESS_ADDR_CONTROL:    readWord = controlWord;
      `STRESS_ADDR_PARAM:      readWord = paramWord;
      `STRESS_ADDR_CHUNK:      readWord = chunk;
      `STRESS_ADDR_TESTCHUNKS: readWord = testChunks;
      `STRESS_ADDR_SAMPLES:    readWord = sampleCount;
      default:                 readWord = '0;
    endcase
    for (int i = 0; i < stressPkg::LaneCount; i++) begin
      if (csrAddress == stressPkg::csrAddr_t'(`STRESS_ADDR_RESULT0 + i)) begin
        readWord = laneSum[i];
      end
    end
  end

  always_ff @(posedge clock) begin
    if (resetSync) begin
      csrReadValid <= 1'b0;
    end else begin
      csrReadValid <= csrRead;  // Data one cycle after strobe.
    end
  end

  always_ff @(posedge clock) begin
    if (csrRead) begin
      csrReadData <= readWord;
    end
  end

endmodule

// File: logic/runTimer.sv
// Run timer that counts prescaled chunks, flags completion and drives incrementing lane stimulus.
`timescale 1ns/1ns

module runTimer (
  input  logic                 clock,
  input  logic                 resetSync,
  input  logic                 go,
  input  stressPkg::chunk_t    testChunks,
  output logic                 done,
  output stressPkg::chunk_t    chunk,
  output logic                 running,
  output stressPkg::laneData_t laneIn [stressPkg::LaneCount]
);

  logic [stressPkg::PrescaleBits-1:0] prescale;
  logic                               prescaleTc;
  logic                               chunkTc;
  logic [stressPkg::RunDelay-1:0]     runPipe;

  always_ff @(posedge clock) begin
    if (resetSync) begin
      prescale   <= '0;
      prescaleTc <= 1'b0;
      chunk      <= '0;
      chunkTc    <= 1'b0;
      done       <= 1'b0;
    end else begin
      prescale   <= go ? prescale + 1'b1 : '0;
      prescaleTc <= &prescale;                  // Last cycle of a chunk.
      chunk      <= go ? chunk + prescaleTc : '0;
      chunkTc    <= (chunk == testChunks);
      // Sticky until the host drops go.
      if (done) begin
        done <= go;
      end else begin
        done <= chunkTc && prescaleTc;
      end
    end
  end

  // Delay line between the run request and the lane stimulus.
  always_ff @(posedge clock) begin
    if (resetSync) begin
      runPipe <= '0;
    end else begin
      runPipe[0] <= go && !done;
      for (int s = 1; s < stressPkg::RunDelay; s++) begin
        runPipe[s] <= runPipe[s-1];
      end
    end
  end

  assign running = runPipe[stressPkg::RunDelay-1];

  // Each lane starts from its own index.
  always_ff @(posedge clock) begin
    for (int i = 0; i < stressPkg::LaneCount; i++) begin
      if (running) begin
        laneIn[i] <= laneIn[i] + 1'b1;
      end else begin
        laneIn[i] <= stressPkg::laneData_t'(i);
      end
    end
  end

endmodule

// File: logic/mixPipeline.sv
// Mixing pipeline applying one keyed rotate-and-add stage per register rank on every lane.
`timescale 1ns/1ns

module mixPipeline (
  input  logic                 clock,
  input  logic                 resetSync,
  input  stressPkg::laneData_t laneIn  [stressPkg::LaneCount],
  output stressPkg::laneData_t laneOut [stressPkg::LaneCount]
);

  // Stage s holds the result after s+1 mixing steps.
  stressPkg::laneData_t stage [stressPkg::PipeStages][stressPkg::LaneCount];

  always_ff @(posedge clock) begin
    if (resetSync) begin
      for (int s = 0; s < stressPkg::PipeStages; s++) begin
        for (int i = 0; i < stressPkg::LaneCount; i++) begin
          stage[s][i] <= '0;
        end
      end
    end else begin
      for (int i = 0; i < stressPkg::LaneCount; i++) begin
        stage[0][i] <= stressPkg::mixStage(laneIn[i], stressPkg::StageKeys[0]);
      end
      for (int s = 1; s < stressPkg::PipeStages; s++) begin
        for (int i = 0; i < stressPkg::LaneCount; i++) begin
          stage[s][i] <= stressPkg::mixStage(stage[s-1][i], stressPkg::StageKeys[s]);
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < stressPkg::LaneCount; i++) begin
      laneOut[i] = stage[stressPkg::PipeStages-1][i];  // PipeStages cycles late.
    end
  end

endmodule

// File: logic/sumCollector.sv
// Result collector that aligns the run window to the pipeline and accumulates lane signatures.
`timescale 1ns/1ns

module sumCollector (
  input  logic                 clock,
  input  logic                 resetSync,
  input  logic                 go,
  input  logic                 running,
  input  stressPkg::laneData_t laneOut [stressPkg::LaneCount],
  output stressPkg::laneData_t laneSum [stressPkg::LaneCount],
  output stressPkg::csrData_t  sampleCount
);

  localparam int WindowDelay = stressPkg::PipeStages + 1;

  logic [1:0]           window [WindowDelay];  // {go, running} per tap.
  logic                 summing;
  logic                 holding;
  stressPkg::laneData_t laneCapture [stressPkg::LaneCount];

  always_ff @(posedge clock) begin
    if (resetSync) begin
      for (int d = 0; d < WindowDelay; d++) begin
        window[d] <= 2'b00;
      end
    end else begin
      window[0] <= {go, running};
      for (int d = 1; d < WindowDelay; d++) begin
        window[d] <= window[d-1];
      end
    end
  end

  assign summing = window[WindowDelay-1][0];
  assign holding = window[WindowDelay-1][1];

  // Capture rank lines the samples up with the extra window cycle.
  always_ff @(posedge clock) begin
    laneCapture <= laneOut;
  end

  always_ff @(posedge clock) begin
    if (resetSync) begin
      sampleCount <= '0;
      for (int i = 0; i < stressPkg::LaneCount; i++) begin
        laneSum[i] <= '0;
      end
    end else if (summing) begin
      sampleCount <= sampleCount + 1'b1;
      for (int i = 0; i < stressPkg::LaneCount; i++) begin
        laneSum[i] <= laneSum[i] + laneCapture[i];  // Wraps at 2^32.
      end
    end else if (!holding) begin
      sampleCount <= '0;
      for (int i = 0; i < stressPkg::LaneCount; i++) begin
        laneSum[i] <= '0;
      end
    end
  end

endmodule

// File: logic/stressTop.sv
// Stress block top level connecting the register file, run timer, mixing pipeline and collector.
`timescale 1ns/1ns

module stressTop (
  input  logic                clock,
  input  logic                resetSync,
  input  logic                csrWrite,
  input  logic                csrRead,
  input  stressPkg::csrAddr_t csrAddress,
  input  stressPkg::csrData_t csrWriteData,
  output stressPkg::csrData_t csrReadData,
  output logic                csrReadValid
);

  logic                 go;
  logic                 done;
  logic                 running;
  stressPkg::chunk_t    testChunks;
  stressPkg::chunk_t    chunk;
  stressPkg::csrData_t  sampleCount;
  stressPkg::laneData_t laneIn  [stressPkg::LaneCount];
  stressPkg::laneData_t laneOut [stressPkg::LaneCount];
  stressPkg::laneData_t laneSum [stressPkg::LaneCount];

  csrBlock uCsr (
    .clock(clock), .resetSync(resetSync),
    .csrWrite(csrWrite), .csrRead(csrRead),
    .csrAddress(csrAddress), .csrWriteData(csrWriteData),
    .done(done), .chunk(chunk), .sampleCount(sampleCount), .laneSum(laneSum),
    .csrReadData(csrReadData), .csrReadValid(csrReadValid),
    .go(go), .testChunks(testChunks)
  );

  runTimer uTimer (
    .clock(clock), .resetSync(resetSync),
    .go(go), .testChunks(testChunks),
    .done(done), .chunk(chunk), .running(running), .laneIn(laneIn)
  );

  mixPipeline uMix (
    .clock(clock), .resetSync(resetSync),
    .laneIn(laneIn), .laneOut(laneOut)
  );

  sumCollector uSum (
    .clock(clock), .resetSync(resetSync),
    .go(go), .running(running), .laneOut(laneOut),
    .laneSum(laneSum), .sampleCount(sampleCount)
  );

endmodule

// File: test/stressTop_sva.sv
// Bound assertions on the stress block read timing and run status levels.
`timescale 1ns/1ns

module stressTopSva (
  input logic clock,
  input logic resetSync,
  input logic csrRead,
  input logic csrReadValid,
  input logic go,
  input logic done,
  input logic running
);

  int failCount = 0;

  readValidAfterRead: assert property (@(posedge clock) disable iff (resetSync)
    csrRead |=> csrReadValid)
    else begin
      $error("csrReadValid missing one cycle after a read strobe");
      failCount++;
    end

  readValidOnlyAfterRead: assert property (@(posedge clock) disable iff (resetSync)
    !csrRead |=> !csrReadValid)
    else begin
      $error("csrReadValid without a read strobe");
      failCount++;
    end

  // Done lags go by one cycle when the host drops it.
  doneNeedsGo: assert property (@(posedge clock) disable iff (resetSync)
    done |-> (go || $past(go)))
    else begin
      $error("done set while go is low");
      failCount++;
    end

  runningStopsAfterDone: assert property (@(posedge clock) disable iff (resetSync)
    $rose(done) |-> ##[0:stressPkg::RunDelay] !running)
    else begin
      $error("running overlaps done for too long");
      failCount++;
    end

endmodule

bind stressTop stressTopSva stressChecks (
  .clock(clock), .resetSync(resetSync),
  .csrRead(csrRead), .csrReadValid(csrReadValid),
  .go(go), .done(done), .running(running)
);

// File: test/stressTb.sv
// Testbench for the stress block that runs timed CSR sessions and checks lane signatures.
`timescale 1ns/1ns
`include "stressDefines.svh"

module stressTb;

  localparam int SettleCycles = stressPkg::RunDelay + stressPkg::PipeStages + 2;
  localparam int ClearCycles  = stressPkg::RunDelay + stressPkg::PipeStages + 4;
  localparam int DoneTimeout  = 400;
  localparam int ReadTimeout  = 8;
  localparam int RotateBits   = 5;
  localparam int ChunkCycles  = 1 << stressPkg::PrescaleBits;

  logic                clock;
  logic                resetSync;
  logic                csrWrite;
  logic                csrRead;
  stressPkg::csrAddr_t csrAddress;
  stressPkg::csrData_t csrWriteData;
  stressPkg::csrData_t csrReadData;
  logic                csrReadValid;

  int unsigned cycleCount = 0;
  int          errorCount = 0;
  int          testCount  = 0;
  int          testErrorsStart = 0;

  // Outstanding reads in issue order.
  bit                  pendingCheck [$];
  string               pendingName [$];
  stressPkg::csrData_t pendingExpected [$];

  stressTop dut (
    .clock(clock), .resetSync(resetSync),
    .csrWrite(csrWrite), .csrRead(csrRead),
    .csrAddress(csrAddress), .csrWriteData(csrWriteData),
    .csrReadData(csrReadData), .csrReadValid(csrReadValid)
  );

  always #20 clock = ~clock;

  always @(posedge clock) begin
    cycleCount <= cycleCount + 1;
  end

  function automatic stressPkg::laneData_t rotateLeft(stressPkg::laneData_t value, int amount);
    return (value << amount) | (value >> (stressPkg::DataWidth - amount));
  endfunction

  // Sum over count samples of lane+k after every mixing stage.
  function automatic stressPkg::laneData_t expectedSum(int lane, int count);
    stressPkg::laneData_t sum;
    stressPkg::laneData_t value;
    sum = '0;
    for (int k = 0; k < count; k++) begin
      value = stressPkg::laneData_t'(lane + k);
      for (int s = 0; s < stressPkg::PipeStages; s++) begin
        value = rotateLeft(value, RotateBits) + stressPkg::StageKeys[s];
      end
      sum = sum + value;
    end
    return sum;
  endfunction

  task automatic checkValue(string name, stressPkg::csrData_t actual,
                            stressPkg::csrData_t expected);
    if (actual !== expected) begin
      $display("MISMATCH %s: got %08h, expected %08h", name, actual, expected);
      errorCount++;
    end
  endtask

  task automatic reportFailure(string reason);
    $display("ERROR: %s", reason);
    errorCount++;
  endtask

  task automatic abortRun(string reason);
    $display("ERROR: %s", reason);
    $display("STATUS: FAIL");
    $finish;
  endtask

  // Matches each returned word to its read.
  always @(negedge clock) begin : compareReads
    bit                  doCheck;
    string               name;
    stressPkg::csrData_t expectedWord;
    if (csrReadValid === 1'b1) begin
      if (pendingName.size() == 0) begin
        reportFailure("read data returned with no read outstanding");
      end else begin
        doCheck      = pendingCheck.pop_front();
        name         = pendingName.pop_front();
        expectedWord = pendingExpected.pop_front();
        if (doCheck) begin
          checkValue(name, csrReadData, expectedWord);
        end
      end
    end
  end

  task automatic csrWriteTask(stressPkg::csrAddr_t address, stressPkg::csrData_t data);
    @(posedge clock);
    #2;
    csrWrite     = 1'b1;
    csrAddress   = address;
    csrWriteData = data;
    @(posedge clock);
    #2;
    csrWrite = 1'b0;
  endtask

  task automatic csrReadTask(stressPkg::csrAddr_t address, bit check, string name,
                             stressPkg::csrData_t expectedWord,
                             output stressPkg::csrData_t data);
    int waited;
    pendingCheck.push_back(check);
    pendingName.push_back(name);
    pendingExpected.push_back(expectedWord);
    @(posedge clock);
    #2;
    csrRead    = 1'b1;
    csrAddress = address;
    @(posedge clock);
    #2;
    csrRead = 1'b0;
    waited  = 0;
    @(negedge clock);
    while (csrReadValid !== 1'b1 && waited < ReadTimeout) begin
      waited++;
      @(negedge clock);
    end
    if (csrReadValid !== 1'b1) begin
      abortRun("read strobe got no read valid within the timeout");
    end else begin
      data = csrReadData;
    end
  endtask

  task automatic checkRead(string name, stressPkg::csrAddr_t address,
                           stressPkg::csrData_t expectedWord);
    stressPkg::csrData_t data;
    csrReadTask(address, 1'b1, name, expectedWord, data);
  endtask

  task automatic pollRead(stressPkg::csrAddr_t address, output stressPkg::csrData_t data);
    csrReadTask(address, 1'b0, "", '0, data);
  endtask

  task automatic finishTest(string name);
    @(posedge clock);  // Lets the compare process drain.
    testCount++;
    if (errorCount == testErrorsStart) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errorCount - testErrorsStart);
    end
    testErrorsStart = errorCount;
  endtask

  task automatic checkResults(int samples);
    for (int i = 0; i < stressPkg::LaneCount; i++) begin
      checkRead($sformatf("RESULT%0d", i), stressPkg::csrAddr_t'(`STRESS_ADDR_RESULT0 + i),
                expectedSum(i, samples));
    end
  endtask

  // Starts a run, polls for done and returns the settled sample count.
  task automatic runToDone(int chunks, output int samples);
    stressPkg::csrData_t word;
    int unsigned         startCycle;
    int                  lowBound;
    bit                  seenDone;
    lowBound = ChunkCycles * (chunks + 1);
    csrWriteTask(`STRESS_ADDR_TESTCHUNKS, chunks);
    csrWriteTask(`STRESS_ADDR_CONTROL, 32'h1);
    startCycle = cycleCount;
    seenDone   = 1'b0;
    while (!seenDone && cycleCount - startCycle < DoneTimeout) begin
      pollRead(`STRESS_ADDR_CONTROL, word);
      seenDone = word[31];
      if (!seenDone) begin
        pollRead(`STRESS_ADDR_CHUNK, word);
        if (word > chunks + 1) begin
          reportFailure($sformatf("chunk count %0d ran past %0d chunks", word, chunks));
        end
      end
    end
    if (!seenDone) begin
      abortRun("done never set within the run timeout");
    end else begin
      repeat (SettleCycles) @(posedge clock);
      pollRead(`STRESS_ADDR_SAMPLES, word);
      samples = int'(word);
      if (samples < lowBound || samples > lowBound + SettleCycles) begin
        reportFailure($sformatf("sample count %0d outside %0d to %0d", samples, lowBound,
                                lowBound + SettleCycles));
      end
    end
  endtask

  task automatic clearAndCheck();
    csrWriteTask(`STRESS_ADDR_CONTROL, 32'h0);
    repeat (ClearCycles) @(posedge clock);
    checkRead("CONTROL", `STRESS_ADDR_CONTROL, 32'h0);
    checkRead("CHUNK", `STRESS_ADDR_CHUNK, 32'h0);
    checkRead("SAMPLES", `STRESS_ADDR_SAMPLES, 32'h0);
    checkResults(0);
  endtask

  initial begin : mainSequence
    stressPkg::csrData_t paramWord;
    int                  samples;
    int                  chunks;
    void'($urandom(32'h7ae2eba3));
    paramWord    = (stressPkg::DataWidth << 16) | stressPkg::PipeStages;
    clock        = 1'b0;
    resetSync    = 1'b1;
    csrWrite     = 1'b0;
    csrRead      = 1'b0;
    csrAddress   = '0;
    csrWriteData = '0;
    repeat (5) @(posedge clock);
    #2;
    resetSync = 1'b0;

    checkRead("ID", `STRESS_ADDR_ID, stressPkg::StressId);
    checkRead("PARAM", `STRESS_ADDR_PARAM, paramWord);
    checkRead("TESTCHUNKS", `STRESS_ADDR_TESTCHUNKS, 32'h0);
    checkRead("CONTROL", `STRESS_ADDR_CONTROL, 32'h0);
    checkRead("CHUNK", `STRESS_ADDR_CHUNK, 32'h0);
    checkRead("SAMPLES", `STRESS_ADDR_SAMPLES, 32'h0);
    checkResults(0);
    finishTest("reset values");

    csrWriteTask(`STRESS_ADDR_CONTROL, 32'hffff_ffff);
    checkRead("CONTROL", `STRESS_ADDR_CONTROL, 32'h1);
    csrWriteTask(`STRESS_ADDR_CONTROL, 32'h0);
    csrWriteTask(`STRESS_ADDR_TESTCHUNKS, 32'h5a5a_c3c3);
    checkRead("TESTCHUNKS", `STRESS_ADDR_TESTCHUNKS, 32'h5a5a_c3c3);
    csrWriteTask(`STRESS_ADDR_TESTCHUNKS, 32'h0);
    csrWriteTask(`STRESS_ADDR_ID, 32'hffff_ffff);
    csrWriteTask(`STRESS_ADDR_PARAM, 32'hffff_ffff);
    csrWriteTask(`STRESS_ADDR_CHUNK, 32'hffff_ffff);
    csrWriteTask(`STRESS_ADDR_SAMPLES, 32'hffff_ffff);
    for (int i = 0; i < stressPkg::LaneCount; i++) begin
      csrWriteTask(stressPkg::csrAddr_t'(`STRESS_ADDR_RESULT0 + i), 32'hffff_ffff);
    end
    repeat (ClearCycles) @(posedge clock);  // Short go pulse above must drain.
    checkRead("ID", `STRESS_ADDR_ID, stressPkg::StressId);
    checkRead("PARAM", `STRESS_ADDR_PARAM, paramWord);
    checkRead("CHUNK", `STRESS_ADDR_CHUNK, 32'h0);
    checkRead("SAMPLES", `STRESS_ADDR_SAMPLES, 32'h0);
    checkResults(0);
    for (int a = `STRESS_ADDR_RESULT0 + stressPkg::LaneCount; a < 16; a++) begin
      checkRead($sformatf("unmapped %0d", a), stressPkg::csrAddr_t'(a), 32'h0);
    end
    finishTest("register masking");

    runToDone(2, samples);
    finishTest("run with 2 chunks");
    checkResults(samples);
    finishTest("lane signatures");
    clearAndCheck();
    finishTest("clear after run");

    for (int r = 0; r < 3; r++) begin
      chunks = $urandom_range(3, 0);
      runToDone(chunks, samples);
      checkResults(samples);
      clearAndCheck();
      finishTest($sformatf("rerun %0d with %0d chunks", r, chunks));
    end

    if (pendingName.size() != 0) begin
      reportFailure("reads still outstanding at the end of the run");
    end
    if (dut.stressChecks.failCount != 0) begin
      reportFailure($sformatf("%0d bound assertion failures", dut.stressChecks.failCount));
    end
    $display("tests %0d, errors %0d", testCount, errorCount);
    if (errorCount == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: all.f
+incdir+include
logic/stressPkg.sv
logic/csrBlock.sv
logic/runTimer.sv
logic/mixPipeline.sv
logic/sumCollector.sv
logic/stressTop.sv
test/stressTop_sva.sv
test/stressTb.sv

// File: Bender.yml
package:
  name: stress_block

export_include_dirs:
  - include

sources:
  - logic/stressPkg.sv
  - logic/csrBlock.sv
  - logic/runTimer.sv
  - logic/mixPipeline.sv
  - logic/sumCollector.sv
  - logic/stressTop.sv
  - target: test
    files:
      - test/stressTop_sva.sv
      - test/stressTb.sv
